/* cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    localparam word_t reset_vector = 32'h0000_0000;
    localparam reg_addr_t link_reg = 5'd31;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j = 6'h02;
    localparam logic [5:0] op_jal = 6'h03;
    localparam logic [5:0] op_beq = 6'h04;
    localparam logic [5:0] op_bne = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti = 6'h0a;
    localparam logic [5:0] op_andi = 6'h0c;
    localparam logic [5:0] op_ori = 6'h0d;
    localparam logic [5:0] op_xori = 6'h0e;
    localparam logic [5:0] op_lui = 6'h0f;
    localparam logic [5:0] op_lb = 6'h20;
    localparam logic [5:0] op_lh = 6'h21;
    localparam logic [5:0] op_lw = 6'h23;
    localparam logic [5:0] op_lbu = 6'h24;
    localparam logic [5:0] op_lhu = 6'h25;
    localparam logic [5:0] op_sb = 6'h28;
    localparam logic [5:0] op_sh = 6'h29;
    localparam logic [5:0] op_sw = 6'h2b;

    // function codes under op_special
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;
    localparam logic [5:0] fn_sra = 6'h03;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_slt = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {src_a_rs, src_a_sa, src_a_pc} src_a_e;
    typedef enum logic [1:0] {src_b_rt, src_b_imm, src_b_eight} src_b_e;
    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

    typedef struct packed {
        word_t pc;
        word_t rs_val;
        word_t rt_val;
        word_t imm;
        logic [4:0] sa;
        alu_op_e alu_op;
        src_a_e src_a;
        src_b_e src_b;
        logic load;
        logic store;
        mem_size_e size;
        logic is_unsigned;
        logic reg_write;
        reg_addr_t wr_addr;
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        word_t result;
        logic [1:0] offset;
        logic load;
        mem_size_e size;
        logic is_unsigned;
        logic reg_write;
        reg_addr_t wr_addr;
    } ex_mem_t;

    typedef struct packed {
        word_t pc;
        logic reg_write;
        reg_addr_t wr_addr;
        word_t wr_data;
    } mem_wb_t;

endpackage

/* fwd_if.sv */
`timescale 1ns/10ps

interface fwd_if;
    logic valid;
    logic we;
    cpu_pkg::reg_addr_t addr;
    cpu_pkg::word_t data;
    // load data not ready while still in execute
    logic is_load;

    modport source (
        output valid,
        output we,
        output addr,
        output data,
        output is_load
    );

    modport sink (
        input valid,
        input we,
        input addr,
        input data,
        input is_load
    );
endinterface

/* pipeline_reg.sv */
`timescale 1ns/10ps

module pipeline_reg #(
    parameter type payload_t = logic [31:0]
) (
    input logic clk,
    input logic reset,
    input logic valid_in,
    input payload_t data_in,
    output logic valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= data_in;
    end

endmodule

/* fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic redirect,
    input cpu_pkg::word_t target,
    output cpu_pkg::word_t inst_addr,
    input cpu_pkg::word_t inst_rdata,
    output cpu_pkg::word_t pc_id,
    output cpu_pkg::word_t inst_id,
    output logic valid_id
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t next_pc;
    logic start;

    // before start, keep requesting the reset vector
    always_comb begin
        if (!start || stall) begin
            next_pc = pc;
        end else if (redirect) begin
            next_pc = target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // memory is synchronous, so the word for pc arrives this cycle
    assign inst_addr = next_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
            pc <= cpu_pkg::reset_vector;
        end else begin
            start <= 1'b1;
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_id <= 1'b0;
        end else if (!stall) begin
            valid_id <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_id <= pc;
            inst_id <= inst_rdata;
        end
    end

endmodule

/* decode_ctrl.sv */
`timescale 1ns/10ps

module decode_ctrl (
    input cpu_pkg::word_t pc_id,
    input cpu_pkg::word_t inst_id,
    input logic valid_id,
    input cpu_pkg::word_t rs_data,
    input cpu_pkg::word_t rt_data,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    output logic redirect,
    output cpu_pkg::word_t target,
    output cpu_pkg::id_ex_t id_ex
);

    logic [5:0] opcode;
    logic [5:0] funct;
    cpu_pkg::word_t delay_pc;
    cpu_pkg::word_t imm_sext;
    cpu_pkg::word_t imm_zext;
    cpu_pkg::mem_size_e access_size;
    logic take_branch;
    logic is_jump;

    assign opcode = inst_id[31:26];
    assign funct = inst_id[5:0];
    assign rs_addr = inst_id[25:21];
    assign rt_addr = inst_id[20:16];
    assign imm_sext = {{16{inst_id[15]}}, inst_id[15:0]};
    assign imm_zext = {16'b0, inst_id[15:0]};
    assign delay_pc = pc_id + 32'd4;

    // low opcode bits give the width for both loads and stores
    assign access_size = !opcode[0] ? cpu_pkg::size_byte :
                         opcode[1] ? cpu_pkg::size_word : cpu_pkg::size_half;

    always_comb begin
        id_ex = '0;
        id_ex.pc = pc_id;
        id_ex.rs_val = rs_data;
        id_ex.rt_val = rt_data;
        id_ex.imm = imm_sext;
        id_ex.sa = inst_id[10:6];
        id_ex.alu_op = cpu_pkg::alu_add;
        id_ex.src_a = cpu_pkg::src_a_rs;
        id_ex.src_b = cpu_pkg::src_b_imm;
        id_ex.size = cpu_pkg::size_word;
        id_ex.wr_addr = rt_addr;
        take_branch = 1'b0;
        is_jump = 1'b0;
        case (opcode)
            cpu_pkg::op_special: begin
                id_ex.src_b = cpu_pkg::src_b_rt;
                id_ex.wr_addr = inst_id[15:11];
                id_ex.reg_write = 1'b1;
                if (funct == cpu_pkg::fn_sll || funct == cpu_pkg::fn_srl
                        || funct == cpu_pkg::fn_sra) begin
                    id_ex.src_a = cpu_pkg::src_a_sa;
                end
                case (funct)
                    cpu_pkg::fn_addu: id_ex.alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: id_ex.alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: id_ex.alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or: id_ex.alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor: id_ex.alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_slt: id_ex.alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sltu: id_ex.alu_op = cpu_pkg::alu_sltu;
                    cpu_pkg::fn_sll: id_ex.alu_op = cpu_pkg::alu_sll;
                    cpu_pkg::fn_srl: id_ex.alu_op = cpu_pkg::alu_srl;
                    cpu_pkg::fn_sra: id_ex.alu_op = cpu_pkg::alu_sra;
                    default: id_ex.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::op_addiu: id_ex.reg_write = 1'b1;
            cpu_pkg::op_slti: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_op = cpu_pkg::alu_slt;
            end
            cpu_pkg::op_andi: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_op = cpu_pkg::alu_and;
                id_ex.imm = imm_zext;
            end
            cpu_pkg::op_ori: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_op = cpu_pkg::alu_or;
                id_ex.imm = imm_zext;
            end
            cpu_pkg::op_xori: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_op = cpu_pkg::alu_xor;
                id_ex.imm = imm_zext;
            end
            cpu_pkg::op_lui: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_op = cpu_pkg::alu_lui;
            end
            cpu_pkg::op_lb, cpu_pkg::op_lbu, cpu_pkg::op_lh, cpu_pkg::op_lhu,
            cpu_pkg::op_lw: begin
                id_ex.load = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.is_unsigned = opcode[2];
                id_ex.size = access_size;
            end
            cpu_pkg::op_sb, cpu_pkg::op_sh, cpu_pkg::op_sw: begin
                id_ex.store = 1'b1;
                id_ex.size = access_size;
            end
            cpu_pkg::op_beq: take_branch = (rs_data == rt_data);
            cpu_pkg::op_bne: take_branch = (rs_data != rt_data);
            cpu_pkg::op_j: is_jump = 1'b1;
            cpu_pkg::op_jal: begin
                // link value pc + 8 is computed by the alu
                is_jump = 1'b1;
                id_ex.reg_write = 1'b1;
                id_ex.wr_addr = cpu_pkg::link_reg;
                id_ex.src_a = cpu_pkg::src_a_pc;
                id_ex.src_b = cpu_pkg::src_b_eight;
            end
            default: id_ex.reg_write = 1'b0;
        endcase
    end

    assign redirect = valid_id && (take_branch || is_jump);
    assign target = is_jump ? {delay_pc[31:28], inst_id[25:0], 2'b00}
                            : delay_pc + {imm_sext[29:0], 2'b00};

endmodule

/* regfile.sv */
`timescale 1ns/10ps

module regfile (
    input logic clk,
    input cpu_pkg::reg_addr_t rs_addr,
    input cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::word_t rs_raw,
    output cpu_pkg::word_t rt_raw,
    fwd_if.sink wr
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr.valid && wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // entry 0 is never written
    assign rs_raw = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_raw = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

/* forward_unit.sv */
`timescale 1ns/10ps

module forward_unit (
    input cpu_pkg::reg_addr_t rs_addr,
    input cpu_pkg::reg_addr_t rt_addr,
    input cpu_pkg::word_t rs_raw,
    input cpu_pkg::word_t rt_raw,
    fwd_if.sink ex,
    fwd_if.sink mem,
    fwd_if.sink wb,
    output cpu_pkg::word_t rs_data,
    output cpu_pkg::word_t rt_data,
    output logic stall
);

    logic rs_ex;
    logic rs_mem;
    logic rs_wb;
    logic rt_ex;
    logic rt_mem;
    logic rt_wb;

    function automatic logic hit(input logic valid, input logic we,
                                 input cpu_pkg::reg_addr_t waddr,
                                 input cpu_pkg::reg_addr_t raddr);
        return valid && we && (waddr == raddr) && (raddr != '0);
    endfunction

    assign rs_ex = hit(ex.valid, ex.we, ex.addr, rs_addr);
    assign rs_mem = hit(mem.valid, mem.we, mem.addr, rs_addr);
    assign rs_wb = hit(wb.valid, wb.we, wb.addr, rs_addr);
    assign rt_ex = hit(ex.valid, ex.we, ex.addr, rt_addr);
    assign rt_mem = hit(mem.valid, mem.we, mem.addr, rt_addr);
    assign rt_wb = hit(wb.valid, wb.we, wb.addr, rt_addr);

    // youngest writer wins
    assign rs_data = rs_ex ? ex.data : rs_mem ? mem.data : rs_wb ? wb.data : rs_raw;
    assign rt_data = rt_ex ? ex.data : rt_mem ? mem.data : rt_wb ? wb.data : rt_raw;

    assign stall = ex.is_load && (rs_ex || rt_ex);

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input logic valid,
    input cpu_pkg::id_ex_t id_ex,
    output cpu_pkg::ex_mem_t ex_mem,
    fwd_if.source fwd,
    output logic data_en,
    output logic [3:0] data_wen,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_wdata
);

    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t result;
    logic [3:0] lanes;

    always_comb begin
        case (id_ex.src_a)
            cpu_pkg::src_a_sa: a = {27'b0, id_ex.sa};
            cpu_pkg::src_a_pc: a = id_ex.pc;
            default: a = id_ex.rs_val;
        endcase
        case (id_ex.src_b)
            cpu_pkg::src_b_imm: b = id_ex.imm;
            cpu_pkg::src_b_eight: b = 32'd8;
            default: b = id_ex.rt_val;
        endcase
    end

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::alu_sub: result = a - b;
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or: result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::alu_sltu: result = {31'b0, a < b};
            cpu_pkg::alu_sll: result = b << a[4:0];
            cpu_pkg::alu_srl: result = b >> a[4:0];
            cpu_pkg::alu_sra: result = $signed(b) >>> a[4:0];
            cpu_pkg::alu_lui: result = {b[15:0], 16'b0};
            default: result = a + b;
        endcase
    end

    // replicate store data so every lane holds it
    always_comb begin
        case (id_ex.size)
            cpu_pkg::size_byte: begin
                lanes = 4'b0001 << result[1:0];
                data_wdata = {4{id_ex.rt_val[7:0]}};
            end
            cpu_pkg::size_half: begin
                lanes = 4'b0011 << {result[1], 1'b0};
                data_wdata = {2{id_ex.rt_val[15:0]}};
            end
            default: begin
                lanes = 4'b1111;
                data_wdata = id_ex.rt_val;
            end
        endcase
    end

    assign data_addr = result;
    assign data_en = valid && (id_ex.load || id_ex.store);
    assign data_wen = (valid && id_ex.store) ? lanes : 4'b0000;

    assign ex_mem.pc = id_ex.pc;
    assign ex_mem.result = result;
    assign ex_mem.offset = result[1:0];
    assign ex_mem.load = id_ex.load;
    assign ex_mem.size = id_ex.size;
    assign ex_mem.is_unsigned = id_ex.is_unsigned;
    assign ex_mem.reg_write = id_ex.reg_write;
    assign ex_mem.wr_addr = id_ex.wr_addr;

    assign fwd.valid = valid;
    assign fwd.we = id_ex.reg_write;
    assign fwd.addr = id_ex.wr_addr;
    assign fwd.data = result;
    assign fwd.is_load = id_ex.load;

endmodule

/* memory_stage.sv */
`timescale 1ns/10ps

module memory_stage (
    input logic valid,
    input cpu_pkg::ex_mem_t ex_mem,
    input cpu_pkg::word_t data_rdata,
    output cpu_pkg::mem_wb_t mem_wb,
    fwd_if.source fwd
);

    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    cpu_pkg::word_t load_data;
    cpu_pkg::word_t wr_data;

    assign byte_sel = data_rdata[{ex_mem.offset, 3'b000} +: 8];
    assign half_sel = data_rdata[{ex_mem.offset[1], 4'b0000} +: 16];

    always_comb begin
        case (ex_mem.size)
            cpu_pkg::size_byte: load_data = {{24{byte_sel[7] && !ex_mem.is_unsigned}}, byte_sel};
            cpu_pkg::size_half: load_data = {{16{half_sel[15] && !ex_mem.is_unsigned}}, half_sel};
            default: load_data = data_rdata;
        endcase
    end

    assign wr_data = ex_mem.load ? load_data : ex_mem.result;

    assign mem_wb.pc = ex_mem.pc;
    assign mem_wb.reg_write = ex_mem.reg_write;
    assign mem_wb.wr_addr = ex_mem.wr_addr;
    assign mem_wb.wr_data = wr_data;

    assign fwd.valid = valid;
    assign fwd.we = ex_mem.reg_write;
    assign fwd.addr = ex_mem.wr_addr;
    assign fwd.data = wr_data;
    assign fwd.is_load = ex_mem.load;

endmodule

/* cpu_top.sv */
`timescale 1ns/10ps

module cpu_top (
    input logic clk,
    input logic reset,
    output cpu_pkg::word_t inst_addr,
    input cpu_pkg::word_t inst_rdata,
    output logic data_en,
    output logic [3:0] data_wen,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_wdata,
    input cpu_pkg::word_t data_rdata,
    output cpu_pkg::word_t debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t debug_wb_rf_wdata
);

    logic stall;
    logic load_use;
    logic redirect;
    cpu_pkg::word_t target;
    cpu_pkg::word_t pc_id;
    cpu_pkg::word_t inst_id;
    logic valid_id;
    cpu_pkg::reg_addr_t rs_addr;
    cpu_pkg::reg_addr_t rt_addr;
    cpu_pkg::word_t rs_raw;
    cpu_pkg::word_t rt_raw;
    cpu_pkg::word_t rs_data;
    cpu_pkg::word_t rt_data;
    cpu_pkg::id_ex_t id_ex_d;
    cpu_pkg::id_ex_t id_ex_q;
    cpu_pkg::ex_mem_t ex_mem_d;
    cpu_pkg::ex_mem_t ex_mem_q;
    cpu_pkg::mem_wb_t mem_wb_d;
    cpu_pkg::mem_wb_t mem_wb_q;
    logic valid_ex;
    logic valid_mem;
    logic valid_wb;

    fwd_if fwd_ex ();
    fwd_if fwd_mem ();
    fwd_if fwd_wb ();

    // a bubble in decode has nothing to wait for
    assign stall = load_use && valid_id;

    fetch_stage fetch (
        .clk(clk), .reset(reset), .stall(stall),
        .redirect(redirect), .target(target),
        .inst_addr(inst_addr), .inst_rdata(inst_rdata),
        .pc_id(pc_id), .inst_id(inst_id), .valid_id(valid_id)
    );

    decode_ctrl decode (
        .pc_id(pc_id), .inst_id(inst_id), .valid_id(valid_id),
        .rs_data(rs_data), .rt_data(rt_data),
        .rs_addr(rs_addr), .rt_addr(rt_addr),
        .redirect(redirect), .target(target), .id_ex(id_ex_d)
    );

    regfile rf (
        .clk(clk), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .rs_raw(rs_raw), .rt_raw(rt_raw), .wr(fwd_wb)
    );

    forward_unit fwd (
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_raw(rs_raw), .rt_raw(rt_raw),
        .ex(fwd_ex), .mem(fwd_mem), .wb(fwd_wb),
        .rs_data(rs_data), .rt_data(rt_data), .stall(load_use)
    );

    pipeline_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .reset(reset),
        .valid_in(valid_id && !stall), .data_in(id_ex_d),
        .valid_out(valid_ex), .data_out(id_ex_q)
    );

    execute_stage execute (
        .valid(valid_ex), .id_ex(id_ex_q), .ex_mem(ex_mem_d), .fwd(fwd_ex),
        .data_en(data_en), .data_wen(data_wen),
        .data_addr(data_addr), .data_wdata(data_wdata)
    );

    pipeline_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .reset(reset),
        .valid_in(valid_ex), .data_in(ex_mem_d),
        .valid_out(valid_mem), .data_out(ex_mem_q)
    );

    memory_stage memory (
        .valid(valid_mem), .ex_mem(ex_mem_q), .data_rdata(data_rdata),
        .mem_wb(mem_wb_d), .fwd(fwd_mem)
    );

    pipeline_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .reset(reset),
        .valid_in(valid_mem), .data_in(mem_wb_d),
        .valid_out(valid_wb), .data_out(mem_wb_q)
    );

    // writeback source feeds both the register file and forwarding
    assign fwd_wb.valid = valid_wb;
    assign fwd_wb.we = mem_wb_q.reg_write;
    assign fwd_wb.addr = mem_wb_q.wr_addr;
    assign fwd_wb.data = mem_wb_q.wr_data;
    assign fwd_wb.is_load = 1'b0;

    assign debug_wb_pc = mem_wb_q.pc;
    assign debug_wb_rf_wen = {4{valid_wb && mem_wb_q.reg_write && mem_wb_q.wr_addr != '0}};
    assign debug_wb_rf_wnum = mem_wb_q.wr_addr;
    assign debug_wb_rf_wdata = mem_wb_q.wr_data;

endmodule

/* tb_cpu_assertions.sv */
`timescale 1ns/10ps

module tb_cpu_assertions (
    input logic clk,
    input logic reset,
    input cpu_pkg::word_t inst_addr,
    input logic data_en,
    input logic [3:0] data_wen,
    input logic [3:0] debug_wb_rf_wen,
    input cpu_pkg::reg_addr_t debug_wb_rf_wnum
);

    wen_lanes_agree: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_wen == 4'b0000 || debug_wb_rf_wen == 4'b1111)
        else $error("trace write enable lanes disagree");

    // register 0 is never a write target
    no_zero_write: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_wen != 4'b0000 |-> debug_wb_rf_wnum != 5'd0)
        else $error("trace reports a write to register 0");

    store_has_enable: assert property (@(posedge clk) disable iff (reset)
        data_wen != 4'b0000 |-> data_en)
        else $error("data write lanes set without data_en");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

endmodule

bind cpu_top tb_cpu_assertions checks (
    .clk(clk),
    .reset(reset),
    .inst_addr(inst_addr),
    .data_en(data_en),
    .data_wen(data_wen),
    .debug_wb_rf_wen(debug_wb_rf_wen),
    .debug_wb_rf_wnum(debug_wb_rf_wnum)
);

/* tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

    logic clk;
    logic reset;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic data_en;
    logic [3:0] data_wen;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    logic [4:0] debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] fetch_addr;
    logic [31:0] load_addr;

    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [4:0] exp_num [$];
    logic [31:0] exp_val [$];

    int cycle_limit = 0;
    int cycle_count;
    int i;

    cpu_top uut (
        .clk(clk), .reset(reset),
        .inst_addr(inst_addr), .inst_rdata(inst_rdata),
        .data_en(data_en), .data_wen(data_wen), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_rdata(data_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic expect_write(input logic [31:0] pc, input logic [4:0] num,
                                input logic [31:0] val);
        exp_pc.push_back(pc);
        exp_num.push_back(num);
        exp_val.push_back(val);
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic build_tables();
        // alu ops, each operand forwarded from execute, memory or writeback
        prog.push_back(itype(6'h09, 5'd0, 5'd1, 16'h0005));
        prog.push_back(itype(6'h09, 5'd0, 5'd2, 16'hfffd));
        prog.push_back(rtype(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
        prog.push_back(rtype(6'h23, 5'd3, 5'd1, 5'd4, 5'd0));
        prog.push_back(rtype(6'h24, 5'd4, 5'd1, 5'd5, 5'd0));
        prog.push_back(rtype(6'h25, 5'd4, 5'd1, 5'd6, 5'd0));
        prog.push_back(rtype(6'h26, 5'd4, 5'd1, 5'd7, 5'd0));
        prog.push_back(rtype(6'h2a, 5'd2, 5'd1, 5'd8, 5'd0));
        prog.push_back(rtype(6'h2b, 5'd2, 5'd1, 5'd9, 5'd0));
        prog.push_back(itype(6'h0f, 5'd0, 5'd10, 16'h8765));
        prog.push_back(itype(6'h0d, 5'd10, 5'd10, 16'h4321));
        prog.push_back(rtype(6'h00, 5'd0, 5'd10, 5'd11, 5'd4));
        prog.push_back(rtype(6'h02, 5'd0, 5'd10, 5'd12, 5'd8));
        prog.push_back(rtype(6'h03, 5'd0, 5'd10, 5'd13, 5'd8));
        prog.push_back(itype(6'h0a, 5'd2, 5'd14, 16'hfffe));
        prog.push_back(itype(6'h0c, 5'd2, 5'd15, 16'hff00));
        prog.push_back(itype(6'h0e, 5'd1, 5'd16, 16'h00ff));
        // sw, sb, sh into one word at 0x40, then read it back
        prog.push_back(itype(6'h2b, 5'd0, 5'd10, 16'h0040));
        prog.push_back(itype(6'h28, 5'd0, 5'd1, 16'h0041));
        prog.push_back(itype(6'h29, 5'd0, 5'd2, 16'h0042));
        prog.push_back(itype(6'h23, 5'd0, 5'd17, 16'h0040));
        prog.push_back(rtype(6'h21, 5'd17, 5'd1, 5'd18, 5'd0));
        prog.push_back(itype(6'h20, 5'd0, 5'd19, 16'h0042));
        prog.push_back(itype(6'h24, 5'd0, 5'd20, 16'h0043));
        prog.push_back(itype(6'h21, 5'd0, 5'd21, 16'h0042));
        prog.push_back(itype(6'h25, 5'd0, 5'd22, 16'h0042));
        // beq taken, bne not taken, j, jal; 0xbad words are skipped
        prog.push_back(itype(6'h04, 5'd1, 5'd5, 16'h0002));
        prog.push_back(itype(6'h09, 5'd0, 5'd23, 16'h0001));
        prog.push_back(itype(6'h09, 5'd0, 5'd24, 16'h0bad));
        prog.push_back(itype(6'h05, 5'd1, 5'd5, 16'h0002));
        prog.push_back(itype(6'h09, 5'd0, 5'd24, 16'h0002));
        prog.push_back(itype(6'h09, 5'd0, 5'd25, 16'h0003));
        prog.push_back(jtype(6'h02, 26'h000_0023));
        prog.push_back(itype(6'h09, 5'd0, 5'd26, 16'h0004));
        prog.push_back(itype(6'h09, 5'd0, 5'd26, 16'h0bad));
        prog.push_back(jtype(6'h03, 26'h000_0026));
        prog.push_back(itype(6'h09, 5'd0, 5'd27, 16'h0005));
        prog.push_back(itype(6'h09, 5'd0, 5'd27, 16'h0bad));
        prog.push_back(rtype(6'h21, 5'd31, 5'd27, 5'd28, 5'd0));

        expect_write(32'h00, 5'd1, 32'h0000_0005);
        expect_write(32'h04, 5'd2, 32'hffff_fffd);
        expect_write(32'h08, 5'd3, 32'h0000_0002);
        expect_write(32'h0c, 5'd4, 32'hffff_fffd);
        expect_write(32'h10, 5'd5, 32'h0000_0005);
        expect_write(32'h14, 5'd6, 32'hffff_fffd);
        expect_write(32'h18, 5'd7, 32'hffff_fff8);
        expect_write(32'h1c, 5'd8, 32'h0000_0001);
        expect_write(32'h20, 5'd9, 32'h0000_0000);
        expect_write(32'h24, 5'd10, 32'h8765_0000);
        expect_write(32'h28, 5'd10, 32'h8765_4321);
        expect_write(32'h2c, 5'd11, 32'h7654_3210);
        expect_write(32'h30, 5'd12, 32'h0087_6543);
        expect_write(32'h34, 5'd13, 32'hff87_6543);
        expect_write(32'h38, 5'd14, 32'h0000_0001);
        expect_write(32'h3c, 5'd15, 32'h0000_ff00);
        expect_write(32'h40, 5'd16, 32'h0000_00fa);
        expect_write(32'h50, 5'd17, 32'hfffd_0521);
        expect_write(32'h54, 5'd18, 32'hfffd_0526);
        expect_write(32'h58, 5'd19, 32'hffff_fffd);
        expect_write(32'h5c, 5'd20, 32'h0000_00ff);
        expect_write(32'h60, 5'd21, 32'hffff_fffd);
        expect_write(32'h64, 5'd22, 32'h0000_fffd);
        expect_write(32'h6c, 5'd23, 32'h0000_0001);
        expect_write(32'h78, 5'd24, 32'h0000_0002);
        expect_write(32'h7c, 5'd25, 32'h0000_0003);
        expect_write(32'h84, 5'd26, 32'h0000_0004);
        expect_write(32'h8c, 5'd31, 32'h0000_0094);
        expect_write(32'h90, 5'd27, 32'h0000_0005);
        expect_write(32'h98, 5'd28, 32'h0000_0099);
    endtask

    task automatic check_write(input int idx);
        assert (debug_wb_pc == exp_pc[idx]) else begin
            fail_run($sformatf("[FAIL] t=%0t debug_wb_pc expected %h actual %h",
                $time, exp_pc[idx], debug_wb_pc));
        end
        assert (debug_wb_rf_wnum == exp_num[idx]) else begin
            fail_run($sformatf("[FAIL] t=%0t debug_wb_rf_wnum expected %0d actual %0d",
                $time, exp_num[idx], debug_wb_rf_wnum));
        end
        assert (debug_wb_rf_wdata == exp_val[idx]) else begin
            fail_run($sformatf("[FAIL] t=%0t debug_wb_rf_wdata expected %h actual %h",
                $time, exp_val[idx], debug_wb_rf_wdata));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // both memories latch the address on the rising edge
    always @(posedge clk) begin
        fetch_addr <= inst_addr;
        // data side acts only on a request
        if (data_en) begin
            load_addr <= data_addr;
            if (data_wen[0]) dmem[data_addr[7:2]][7:0] <= data_wdata[7:0];
            if (data_wen[1]) dmem[data_addr[7:2]][15:8] <= data_wdata[15:8];
            if (data_wen[2]) dmem[data_addr[7:2]][23:16] <= data_wdata[23:16];
            if (data_wen[3]) dmem[data_addr[7:2]][31:24] <= data_wdata[31:24];
        end
    end

    always @(negedge clk) begin
        inst_rdata = (fetch_addr < 32'h100) ? imem[fetch_addr[7:2]] : 32'h0;
        data_rdata = dmem[load_addr[7:2]];
    end

    initial begin
        wait (cycle_limit != 0);
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        fail_run($sformatf("timeout: trace not complete after %0d cycles", cycle_limit));
    end

    initial begin
        reset = 1'b1;
        inst_rdata = 32'h0;
        data_rdata = 32'h0;
        fetch_addr = 32'h0;
        load_addr = 32'h0;
        build_tables();
        // zero words decode as nop
        for (i = 0; i < 64; i++) begin
            imem[i[5:0]] = 32'h0;
            dmem[i[5:0]] = 32'h0;
        end
        for (i = 0; i < prog.size(); i++) begin
            imem[i[5:0]] = prog[i];
        end
        cycle_limit = 8 + 2 * prog.size() + 40;

        repeat (8) @(negedge clk);
        reset = 1'b0;

        for (i = 0; i < exp_pc.size(); i++) begin
            @(negedge clk);
            while (debug_wb_rf_wen == 4'b0000) begin
                @(negedge clk);
            end
            check_write(i);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* sources.f */
cpu_pkg.sv
fwd_if.sv
pipeline_reg.sv
fetch_stage.sv
decode_ctrl.sv
regfile.sv
forward_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu_assertions.sv
tb_cpu.sv

/* Makefile */
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
